// ==== rx_params.svh ====
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// width of one I or Q sample word in bits
`define RX_SAMPLE_BW 16

// number of integrator stages, and also the number of comb stages
`define RX_CIC_ORDER 4

// log2 of the highest supported decimation rate, so rates up to 128
`define RX_LOG2_MAX_RATE 7

// the accumulator has to hold the full gain of rate to the power of the order
`define RX_ACC_BW ((`RX_SAMPLE_BW) + (`RX_CIC_ORDER) * (`RX_LOG2_MAX_RATE))

`endif

// ==== rx_pkg.sv ====
`include "rx_params.svh"

package rx_pkg;

   // one signed I or Q sample as it enters and leaves the decimator
   typedef logic signed [`RX_SAMPLE_BW-1:0] sample_t;

   // integrator and comb word, wide enough for the worst case filter gain
   // and allowed to wrap, since the comb stages undo the overflow
   typedef logic signed [`RX_ACC_BW-1:0] acc_t;

   // decimation rate, legal values 1 to 128
   typedef logic [`RX_LOG2_MAX_RATE:0] rate_t;

   // right shift that normalizes the filter gain, at most 28
   typedef logic [5:0] shift_t;

   // packed output pair with Q in the upper half and I in the lower half
   typedef logic [2*`RX_SAMPLE_BW-1:0] iq_word_t;

endpackage

// ==== rate_strobe_gen.sv ====
module rate_strobe_gen
(
   input  logic          clock,
   input  logic          reset,
   input  logic          enable,
   input  rx_pkg::rate_t rate,
   input  logic          strobe_in,
   output logic          decim_strobe
);

   // counts the input strobes seen since the last decimated strobe
   rx_pkg::rate_t count;

   // high while the counter sits on the last input strobe of a period
   logic last_count;

   // with a rate of 1 the last count is zero, so every input strobe passes
   assign last_count = (count == rate - rx_pkg::rate_t'(1));

   // the output strobe comes out in the same cycle as the input strobe
   // that completes the period, it never fires without strobe_in
   assign decim_strobe = enable && strobe_in && last_count;

   always_ff @(posedge clock)
   begin
      if (reset)
         count <= '0;
      else if (!enable)
         // a disabled chain starts a fresh period once it is enabled again
         count <= '0;
      else if (strobe_in)
      begin
         if (last_count)
            count <= '0;
         else
            count <= count + rx_pkg::rate_t'(1);
      end
   end

endmodule

// ==== cic_dec_shifter.sv ====
`include "rx_params.svh"

module cic_dec_shifter
(
   input  rx_pkg::rate_t   rate,
   input  rx_pkg::acc_t    acc_in,
   output rx_pkg::sample_t sample_out
);

   // ceiling of log2 of the rate, 0 for a rate of 1 and 7 for 65 to 128
   rx_pkg::shift_t rate_log2;

   // total right shift, the order times the ceiling of log2 of the rate
   rx_pkg::shift_t shift;

   // comb output after the arithmetic shift, still at full width
   rx_pkg::acc_t acc_shifted;

   // the filter gain is rate to the power of the order, so the word grows
   // by order times log2(rate) bits and that many bits are dropped again
   always_comb
   begin
      rate_log2 = '0;
      // each power of two that the rate exceeds adds one bit of growth
      for (int k = 0; k < `RX_LOG2_MAX_RATE; k++)
      begin
         if (rate > rx_pkg::rate_t'(1 << k))
            rate_log2 = rx_pkg::shift_t'(k + 1);
      end
   end

   // 0 for rate 1, 4 for rate 2, 8 for rates 3 and 4, up to 28
   assign shift = rx_pkg::shift_t'(rate_log2 * `RX_CIC_ORDER);

   // an arithmetic shift rounds toward minus infinity, which gives the
   // floor for negative inputs as well
   assign acc_shifted = acc_in >>> shift;

   // for rates that are not a power of two the gain is below the shift,
   // so the result is attenuated and always fits in the sample width
   assign sample_out = acc_shifted[`RX_SAMPLE_BW-1:0];

endmodule

// ==== cic_decim.sv ====
`include "rx_params.svh"

module cic_decim
(
   input  logic            clock,
   input  logic            reset,
   input  logic            enable,
   input  rx_pkg::rate_t   rate,
   input  logic            strobe_in,
   input  logic            decim_strobe,
   input  rx_pkg::sample_t signal_in,
   output rx_pkg::sample_t signal_out
);

   // input sample widened to the accumulator width with its sign
   rx_pkg::acc_t signal_ext;

   // integrator chain, running at the input sample rate
   rx_pkg::acc_t integrator [`RX_CIC_ORDER];

   // last integrator value, held at the decimated rate
   rx_pkg::acc_t sampler;

   // previous input of each comb stage, one decimated sample back
   rx_pkg::acc_t comb_delay [`RX_CIC_ORDER];

   // registered output of each comb stage
   rx_pkg::acc_t comb [`RX_CIC_ORDER];

   // unnormalized filter result handed to the shifter
   rx_pkg::acc_t comb_out;

   // sample_t is signed, so the cast repeats the sign bit
   assign signal_ext = rx_pkg::acc_t'(signal_in);

   // every integrator adds its predecessor once per input strobe
   // the sums wrap freely, the comb differences remove the wrap again
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < `RX_CIC_ORDER; i++)
            integrator[i] <= '0;
      end
      else if (enable && strobe_in)
      begin
         integrator[0] <= integrator[0] + signal_ext;
         for (int i = 1; i < `RX_CIC_ORDER; i++)
            integrator[i] <= integrator[i] + integrator[i-1];
      end
   end

   // the sampler and the combs all move one step per decimated strobe
   // each stage works on the value its predecessor held before this edge,
   // so a sample taken at strobe k leaves the last comb at strobe k+4
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         sampler <= '0;
         for (int i = 0; i < `RX_CIC_ORDER; i++)
         begin
            comb_delay[i] <= '0;
            comb[i]       <= '0;
         end
      end
      else if (enable && decim_strobe)
      begin
         sampler       <= integrator[`RX_CIC_ORDER-1];
         comb_delay[0] <= sampler;
         comb[0]       <= sampler - comb_delay[0];
         for (int i = 1; i < `RX_CIC_ORDER; i++)
         begin
            comb_delay[i] <= comb[i-1];
            comb[i]       <= comb[i-1] - comb_delay[i];
         end
      end
   end

   assign comb_out = comb[`RX_CIC_ORDER-1];

   // the gain of rate to the fourth power is taken out here
   cic_dec_shifter shifter_i
   (
      .rate       (rate),
      .acc_in     (comb_out),
      .sample_out (signal_out)
   );

endmodule

// ==== iq_sample_pack.sv ====
module iq_sample_pack
(
   input  logic             clock,
   input  logic             reset,
   input  logic             enable,
   input  logic             decim_strobe,
   input  rx_pkg::sample_t  i_in,
   input  rx_pkg::sample_t  q_in,
   output rx_pkg::iq_word_t iq_out,
   output logic             out_strobe
);

   // qualified decimated strobe, one cycle late
   logic strobe_d;

   // last pair presented with an output strobe
   rx_pkg::iq_word_t pair_q;

   // the current decimator results, Q high and I low
   rx_pkg::iq_word_t pair_now;

   assign pair_now = {q_in, i_in};

   // the combs update on the decimated strobe edge, so their new results
   // are visible in the cycle after it, which is where this strobe lands
   always_ff @(posedge clock)
   begin
      if (reset)
         strobe_d <= 1'b0;
      else
         strobe_d <= enable && decim_strobe;
   end

   // hold the pair until the next output strobe replaces it
   always_ff @(posedge clock)
   begin
      if (reset)
         pair_q <= '0;
      else if (strobe_d)
         pair_q <= pair_now;
   end

   assign out_strobe = strobe_d;

   // during the strobe cycle the fresh pair is shown directly, after it the held copy
   assign iq_out = strobe_d ? pair_now : pair_q;

endmodule

// ==== rx_decim_top.sv ====
module rx_decim_top
(
   input  logic             clock,
   input  logic             reset,
   input  logic             enable,
   input  rx_pkg::rate_t    rate,
   input  logic             strobe_in,
   input  rx_pkg::sample_t  i_in,
   input  rx_pkg::sample_t  q_in,
   output rx_pkg::iq_word_t iq_out,
   output logic             out_strobe
);

   // one pulse per rate input strobes, shared by both channels
   logic decim_strobe;

   // normalized decimator results
   rx_pkg::sample_t i_decim;
   rx_pkg::sample_t q_decim;

   rate_strobe_gen strobe_gen_i
   (
      .clock        (clock),
      .reset        (reset),
      .enable       (enable),
      .rate         (rate),
      .strobe_in    (strobe_in),
      .decim_strobe (decim_strobe)
   );

   // I and Q see the same strobes, so their pipelines stay aligned
   cic_decim cic_i
   (
      .clock        (clock),
      .reset        (reset),
      .enable       (enable),
      .rate         (rate),
      .strobe_in    (strobe_in),
      .decim_strobe (decim_strobe),
      .signal_in    (i_in),
      .signal_out   (i_decim)
   );

   cic_decim cic_q
   (
      .clock        (clock),
      .reset        (reset),
      .enable       (enable),
      .rate         (rate),
      .strobe_in    (strobe_in),
      .decim_strobe (decim_strobe),
      .signal_in    (q_in),
      .signal_out   (q_decim)
   );

   iq_sample_pack pack_i
   (
      .clock        (clock),
      .reset        (reset),
      .enable       (enable),
      .decim_strobe (decim_strobe),
      .i_in         (i_decim),
      .q_in         (q_decim),
      .iq_out       (iq_out),
      .out_strobe   (out_strobe)
   );

endmodule

// ==== rx_decim_tb_assertions.sv ====
module rx_decim_tb_assertions
(
   input logic clock,
   input logic reset,
   input logic decim_strobe,
   input logic out_strobe
);
   timeunit 1ns;
   timeprecision 1ps;

   // the output strobe is a single cycle pulse
   single_cycle_out_strobe: assert property
      (@(posedge clock) disable iff (reset) out_strobe |=> !out_strobe)
      else $error("out_strobe stayed high for two cycles in a row");

   // a cycle of reset clears the delayed strobe, so nothing comes out behind it
   no_out_strobe_in_reset: assert property
      (@(posedge clock) reset |=> !out_strobe)
      else $error("out_strobe was high right after a reset cycle");

   // the packer only fires one cycle after a qualified decimated strobe
   out_strobe_after_decim: assert property
      (@(posedge clock) disable iff (reset) out_strobe |-> $past(decim_strobe))
      else $error("out_strobe without a decim_strobe in the cycle before");

endmodule

// decim_strobe is the internal net between the strobe generator and the packer
bind rx_decim_top rx_decim_tb_assertions assertions_i
(
   .clock        (clock),
   .reset        (reset),
   .decim_strobe (decim_strobe),
   .out_strobe   (out_strobe)
);

// ==== rx_decim_tb.sv ====
`include "rx_params.svh"

module rx_decim_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // the comb registers start at zero after reset, which only matches the
   // integrator polynomial once five fresh sampler values are in the combs,
   // so the first exact decimated output is the ninth one
   localparam int SETTLE_OUTPUTS = 8;
   localparam int CHECK_OUTPUTS = 4;

   logic             clock;
   logic             reset;
   logic             enable;
   rx_pkg::rate_t    rate;
   logic             strobe_in;
   rx_pkg::sample_t  i_in;
   rx_pkg::sample_t  q_in;
   rx_pkg::iq_word_t iq_out;
   logic             out_strobe;

   // state of the pseudo random sequence for the test samples
   logic [31:0] lcg_state;

   rx_decim_top dut_i
   (
      .clock      (clock),
      .reset      (reset),
      .enable     (enable),
      .rate       (rate),
      .strobe_in  (strobe_in),
      .i_in       (i_in),
      .q_in       (q_in),
      .iq_out     (iq_out),
      .out_strobe (out_strobe)
   );

   always #50 clock = ~clock;

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // the upper bits of an LCG are the better distributed ones
   function automatic rx_pkg::sample_t random_sample();
      logic [31:0] r;
      r = next_random();
      return rx_pkg::sample_t'(r[31:16]);
   endfunction

   function automatic rx_pkg::sample_t negative_sample();
      rx_pkg::sample_t r;
      r = random_sample();
      return {1'b1, r[14:0]};
   endfunction

   // settled DC response, floor of x times rate^order over 2^(order*ceil(log2 rate))
   function automatic rx_pkg::sample_t expected_dc(rx_pkg::sample_t x, rx_pkg::rate_t r);
      longint gain;
      longint full;
      int     ceil_log2;
      gain = 1;
      for (int k = 0; k < `RX_CIC_ORDER; k++)
         gain = gain * longint'(r);
      ceil_log2 = 0;
      while ((longint'(1) << ceil_log2) < longint'(r))
         ceil_log2++;
      // an arithmetic shift of the signed product is the floor, negative or not
      full = (longint'(x) * gain) >>> (`RX_CIC_ORDER * ceil_log2);
      return full[`RX_SAMPLE_BW-1:0];
   endfunction

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(logic [31:0] actual, logic [31:0] expected, string what);
      assert (actual == expected)
      else
      begin
         $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                  $time, what, actual, expected);
         abort_run();
      end
   endtask

   task automatic apply_reset();
      @(negedge clock);
      reset = 1'b1;
      strobe_in = 1'b0;
      repeat (4) @(negedge clock);
      reset = 1'b0;
   endtask

   // one input strobe followed by an idle cycle, called on a falling edge
   // the response to the strobe shows up one cycle later
   task automatic send_strobe(output logic got, output rx_pkg::iq_word_t word);
      strobe_in = 1'b1;
      @(negedge clock);
      strobe_in = 1'b0;
      got = out_strobe;
      word = iq_out;
      @(negedge clock);
      check_value(32'(out_strobe), 32'd0, "out_strobe high in the idle cycle");
   endtask

   task automatic wait_output(int limit, output rx_pkg::iq_word_t word, output int used);
      logic got;
      int   sent;
      sent = 0;
      got = 1'b0;
      while (!got)
      begin
         if (sent >= limit)
         begin
            $display("timeout: no out_strobe within %0d input strobes", limit);
            abort_run();
         end
         send_strobe(got, word);
         sent++;
      end
      used = sent;
   endtask

   // constant input, fill the pipeline, then compare a few settled outputs
   task automatic run_dc(rx_pkg::rate_t r, rx_pkg::sample_t i_val,
                         rx_pkg::sample_t q_val, bit do_reset, string what);
      rx_pkg::iq_word_t word;
      rx_pkg::iq_word_t expected;
      int               used;
      rate = r;
      i_in = i_val;
      q_in = q_val;
      if (do_reset)
         apply_reset();
      expected = {expected_dc(q_val, r), expected_dc(i_val, r)};
      for (int n = 0; n < SETTLE_OUTPUTS + CHECK_OUTPUTS; n++)
      begin
         wait_output(int'(r) + 1, word, used);
         // the counter starts from zero, so every output is rate strobes apart
         check_value(used, int'(r), {what, ", input strobes per output"});
         if (n >= SETTLE_OUTPUTS)
            check_value(word, expected, {what, ", settled iq_out"});
      end
   endtask

   task automatic count_strobes(rx_pkg::rate_t r);
      rx_pkg::iq_word_t word;
      logic             got;
      int               seen;
      rate = r;
      apply_reset();
      seen = 0;
      for (int n = 0; n < 3 * int'(r); n++)
      begin
         send_strobe(got, word);
         if (got)
            seen++;
      end
      check_value(seen, 32'd3, "out_strobes over three rate periods");
   endtask

   task automatic hold_while_disabled();
      rx_pkg::iq_word_t word;
      rx_pkg::iq_word_t held;
      rx_pkg::iq_word_t expected;
      rx_pkg::sample_t  i_val;
      rx_pkg::sample_t  q_val;
      logic             got;
      int               used;
      i_val = random_sample();
      q_val = random_sample();
      expected = {expected_dc(q_val, 8'd8), expected_dc(i_val, 8'd8)};
      run_dc(8'd8, i_val, q_val, 1'b1, "dc before enable low");
      wait_output(9, held, used);
      check_value(held, expected, "iq_out before enable low");
      enable = 1'b0;
      for (int n = 0; n < 24; n++)
      begin
         send_strobe(got, word);
         check_value(32'(got), 32'd0, "out_strobe while enable is low");
         check_value(word, held, "iq_out while enable is low");
      end
      // the whole chain was frozen, so the DC value simply continues
      enable = 1'b1;
      wait_output(9, word, used);
      check_value(used, 32'd8, "input strobes to the first output after enable");
      check_value(word, expected, "iq_out after enable returns");
   endtask

   task automatic reset_mid_run();
      rx_pkg::iq_word_t word;
      logic             got;
      run_dc(8'd8, random_sample(), random_sample(), 1'b1, "dc before mid-run reset");
      // land the reset part way through a decimation period
      repeat (5) send_strobe(got, word);
      apply_reset();
      check_value(iq_out, 32'd0, "iq_out after mid-run reset");
      check_value(32'(out_strobe), 32'd0, "out_strobe after mid-run reset");
      run_dc(8'd8, random_sample(), negative_sample(), 1'b0, "dc after mid-run reset");
   endtask

   initial
   begin
      clock = 1'b0;
      reset = 1'b1;
      enable = 1'b1;
      rate = 8'd8;
      strobe_in = 1'b0;
      i_in = '0;
      q_in = '0;
      lcg_state = 32'he566_8926;
      apply_reset();

      run_dc(8'd8, random_sample(), random_sample(), 1'b1, "dc at rate 8");
      run_dc(8'd1, random_sample(), random_sample(), 1'b1, "dc at rate 1");
      run_dc(8'd5, random_sample(), random_sample(), 1'b1, "dc at rate 5");
      run_dc(8'd5, negative_sample(), negative_sample(), 1'b1, "negative dc at rate 5");
      count_strobes(8'd4);
      count_strobes(8'd16);
      hold_while_disabled();
      reset_mid_run();

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+.
rx_pkg.sv
rate_strobe_gen.sv
cic_dec_shifter.sv
cic_decim.sv
iq_sample_pack.sv
rx_decim_top.sv
rx_decim_tb_assertions.sv
rx_decim_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is the status of the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rx_decim_tb -f tb.f -o rx_decim_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/rx_decim_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
